// ==== hw/ecc_drbg_cmd_pkg.sv ====
package ecc_drbg_cmd_pkg;

`include "ecc_drbg_defs.svh"

    // requested operation
    typedef enum logic [1:0] {
        MODE_KEYGEN    = 2'b00,
        MODE_SIGN      = 2'b01,
        MODE_DH_SHARED = 2'b10
    } drbg_mode_e;

    // request as frozen at acceptance
    typedef struct packed {
        drbg_mode_e                    mode;
        logic [`ECC_DRBG_REG_SIZE-1:0] keygen_seed;
        logic [`ECC_DRBG_REG_SIZE-1:0] keygen_nonce;
        logic [`ECC_DRBG_REG_SIZE-1:0] priv_key;
        logic [`ECC_DRBG_REG_SIZE-1:0] hashed_msg;
        logic [`ECC_DRBG_REG_SIZE-1:0] iv;
        // operation count, replicated across the word
        logic [`ECC_DRBG_REG_SIZE-1:0] counter_nonce;
    } drbg_req_t;

endpackage

// ==== hw/ecc_drbg_core_pkg.sv ====
package ecc_drbg_core_pkg;

`include "ecc_drbg_defs.svh"

    // sequencer steps, one generator command per step state
    typedef enum logic [3:0] {
        IDLE     = 4'd0,
        SEED     = 4'd1,
        LAMBDA   = 4'd2,
        SCALAR   = 4'd3,
        RND_DONE = 4'd4,
        MASKING  = 4'd5,
        KEYGEN   = 4'd6,
        SIGN     = 4'd7,
        DONE     = 4'd8
    } drbg_state_e;

    // command to the generator core, strobes last one cycle
    typedef struct packed {
        logic                          init_cmd;
        logic                          next_cmd;
        logic [`ECC_DRBG_REG_SIZE-1:0] entropy;
        logic [`ECC_DRBG_REG_SIZE-1:0] nonce;
    } drbg_core_cmd_t;

    // result bank register addressed by a write
    typedef enum logic [2:0] {
        SEED_D    = 3'd0,
        LAMBDA_D  = 3'd1,
        SCALAR_D  = 3'd2,
        MASKING_D = 3'd3,
        K_D       = 3'd4
    } drbg_dest_e;

endpackage

// ==== hw/ecc_drbg_defs.svh ====
`ifndef ECC_DRBG_DEFS_SVH
`define ECC_DRBG_DEFS_SVH

// datapath word width
`define ECC_DRBG_REG_SIZE 64

// mixer rounds per init or next command
`define ECC_DRBG_ROUNDS 8

// largest 64-bit prime, odd and just below 2^64
`define ECC_DRBG_GROUP_ORDER 64'hffff_ffff_ffff_ffc5

// refreshed seed value after reset or zeroize
`define ECC_DRBG_SEED_INIT 64'hc485_5592_9cd5_8779

`endif

// ==== hw/ecc_drbg_mix_core.sv ====
`timescale 1ns/100ps

`include "ecc_drbg_defs.svh"

module ecc_drbg_mix_core
    import ecc_drbg_core_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize,
    input  drbg_core_cmd_t                cmd,
    input  logic [`ECC_DRBG_REG_SIZE-1:0] seed_in,
    output logic                          valid,
    output logic [`ECC_DRBG_REG_SIZE-1:0] result
);

    localparam int           W      = `ECC_DRBG_REG_SIZE;
    localparam int           ROUNDS = `ECC_DRBG_ROUNDS;
    localparam int           RND_W  = $clog2(ROUNDS + 1);
    localparam logic [W-1:0] ORDER  = `ECC_DRBG_GROUP_ORDER;

    logic [W-1:0]     key_reg;
    logic [W-1:0]     state_reg;
    logic [W-1:0]     round_state;
    logic [7:0]       step_cnt;
    logic [7:0]       step_inc;
    logic [RND_W-1:0] rnd_cnt;
    logic             busy;
    logic             reduce_cycle;
    logic             strobe;

    assign strobe       = cmd.init_cmd | cmd.next_cmd;
    assign step_inc     = step_cnt + 8'd1;
    // all rounds done, only the reduction is left
    assign reduce_cycle = (rnd_cnt == RND_W'(ROUNDS));

    // one round, rotl 13, xor key, add round index
    assign round_state = ({state_reg[W-14:0], state_reg[W-1:W-13]} ^ key_reg)
                         + W'(rnd_cnt);

    // ------------------------------------------------------------------
    // round control
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            busy     <= 1'b0;
            valid    <= 1'b0;
            rnd_cnt  <= '0;
            step_cnt <= '0;
        end
        else if (zeroize)
        begin
            busy     <= 1'b0;
            valid    <= 1'b0;
            rnd_cnt  <= '0;
            step_cnt <= '0;
        end
        else if (strobe)
        begin
            busy     <= 1'b1;
            valid    <= 1'b0;
            rnd_cnt  <= '0;
            step_cnt <= cmd.init_cmd ? 8'd0 : step_inc;
        end
        else if (busy)
        begin
            if (reduce_cycle)
            begin
                busy  <= 1'b0;
                valid <= 1'b1;
            end
            else
                rnd_cnt <= rnd_cnt + RND_W'(1);
        end
    end

    // ------------------------------------------------------------------
    // mixer datapath
    // ------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (zeroize)
        begin
            key_reg   <= '0;
            state_reg <= '0;
            result    <= '0;
        end
        else if (cmd.init_cmd)
        begin
            key_reg   <= cmd.entropy ^ cmd.nonce;
            state_reg <= seed_in;
        end
        // next keeps the key, folds in the step count
        else if (cmd.next_cmd)
            state_reg <= state_reg ^ W'(step_inc);
        else if (busy)
        begin
            // single subtraction brings the state below the order
            if (reduce_cycle)
                result <= (state_reg >= ORDER) ? state_reg - ORDER : state_reg;
            else
            begin
                state_reg <= round_state;
                // key rotr 7, carries over into later commands
                key_reg   <= {key_reg[6:0], key_reg[W-1:7]};
            end
        end
    end

endmodule

// ==== hw/ecc_drbg_req_capture.sv ====
`timescale 1ns/100ps

`include "ecc_drbg_defs.svh"

module ecc_drbg_req_capture
    import ecc_drbg_cmd_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          en,
    input  logic                          ready,
    input  drbg_mode_e                    mode,
    input  logic [`ECC_DRBG_REG_SIZE-1:0] keygen_seed,
    input  logic [`ECC_DRBG_REG_SIZE-1:0] keygen_nonce,
    input  logic [`ECC_DRBG_REG_SIZE-1:0] priv_key,
    input  logic [`ECC_DRBG_REG_SIZE-1:0] hashed_msg,
    input  logic [`ECC_DRBG_REG_SIZE-1:0] iv,
    output logic                          start,
    output drbg_req_t                     req
);

    // count width, replicated to fill one word
    localparam int CNT_W = 16;

    logic [CNT_W-1:0] op_count;
    logic [CNT_W-1:0] op_count_next;
    logic             accept;

    // en only counts while the sequencer is idle
    assign accept        = en & ready;
    assign start         = accept;
    assign op_count_next = op_count + CNT_W'(1);

    // operation counter, only moves forward
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            op_count <= '0;
        else if (accept)
            op_count <= op_count_next;
    end

    // operands frozen for the whole operation
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req.mode          <= mode;
            req.keygen_seed   <= keygen_seed;
            req.keygen_nonce  <= keygen_nonce;
            req.priv_key      <= priv_key;
            req.hashed_msg    <= hashed_msg;
            req.iv            <= iv;
            // new count goes out with this request
            req.counter_nonce <= {(`ECC_DRBG_REG_SIZE/CNT_W){op_count_next}};
        end
    end

endmodule

// ==== hw/ecc_drbg_result_bank.sv ====
`timescale 1ns/100ps

`include "ecc_drbg_defs.svh"

module ecc_drbg_result_bank
    import ecc_drbg_core_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize,
    input  logic                          wr_en,
    input  drbg_dest_e                    wr_dest,
    input  logic [`ECC_DRBG_REG_SIZE-1:0] wr_data,
    output logic [`ECC_DRBG_REG_SIZE-1:0] seed,
    output logic [`ECC_DRBG_REG_SIZE-1:0] lambda,
    output logic [`ECC_DRBG_REG_SIZE-1:0] scalar_rnd,
    output logic [`ECC_DRBG_REG_SIZE-1:0] masking_rnd,
    output logic [`ECC_DRBG_REG_SIZE-1:0] drbg
);

    // bank holds until overwritten, zeroize wipes it
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            seed        <= `ECC_DRBG_SEED_INIT;
            lambda      <= '0;
            scalar_rnd  <= '0;
            masking_rnd <= '0;
            drbg        <= '0;
        end
        else if (zeroize)
        begin
            seed        <= `ECC_DRBG_SEED_INIT;
            lambda      <= '0;
            scalar_rnd  <= '0;
            masking_rnd <= '0;
            drbg        <= '0;
        end
        else if (wr_en)
        begin
            case (wr_dest)
                // refreshed seed, chains into later operations
                SEED_D:    seed        <= wr_data;
                LAMBDA_D:  lambda      <= wr_data;
                SCALAR_D:  scalar_rnd  <= wr_data;
                MASKING_D: masking_rnd <= wr_data;
                // privkey in keygen, k in sign
                K_D:       drbg        <= wr_data;
                default:   drbg        <= drbg;
            endcase
        end
    end

endmodule

// ==== hw/ecc_drbg_sequencer.sv ====
`timescale 1ns/100ps

`include "ecc_drbg_defs.svh"

module ecc_drbg_sequencer
    import ecc_drbg_cmd_pkg::*, ecc_drbg_core_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize,
    input  logic                          start,
    input  drbg_req_t                     req,
    input  logic [`ECC_DRBG_REG_SIZE-1:0] seed,
    input  logic                          core_valid,
    output drbg_core_cmd_t                core_cmd,
    output logic [`ECC_DRBG_REG_SIZE-1:0] seed_in,
    output logic                          wr_en,
    output drbg_dest_e                    wr_dest,
    output logic                          ready,
    output logic                          done
);

    drbg_state_e state_reg;
    drbg_state_e state_next;
    drbg_state_e state_last;
    logic        valid_last;
    logic        first_cycle;
    logic        core_done;
    logic        step_state;

    // ------------------------------------------------------------------
    // step detection
    // ------------------------------------------------------------------

    // state just changed, so this is the strobe cycle
    assign first_cycle = (state_reg != state_last);
    // rising valid ends the running step
    assign core_done   = core_valid & ~valid_last;

    // seed refresh mixes in the fresh count
    assign seed_in = seed ^ req.counter_nonce;
    assign ready   = (state_reg == IDLE);
    assign done    = (state_reg == DONE);
    assign wr_en   = core_done & step_state;

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            state_reg  <= IDLE;
            state_last <= IDLE;
            valid_last <= 1'b0;
        end
        else if (zeroize)
        begin
            state_reg  <= IDLE;
            state_last <= IDLE;
            valid_last <= 1'b0;
        end
        else
        begin
            state_reg  <= state_next;
            state_last <= state_reg;
            valid_last <= core_valid;
        end
    end

    // ------------------------------------------------------------------
    // step order
    // ------------------------------------------------------------------
    always_comb
    begin
        state_next = state_reg;
        case (state_reg)
            IDLE:     state_next = start ? SEED : IDLE;
            SEED:     state_next = core_done ? LAMBDA : SEED;
            LAMBDA:   state_next = core_done ? SCALAR : LAMBDA;
            SCALAR:   state_next = core_done ? RND_DONE : SCALAR;
            // mode picks the tail of the operation
            RND_DONE: state_next = (req.mode == MODE_SIGN)   ? MASKING :
                                   (req.mode == MODE_KEYGEN) ? KEYGEN  : DONE;
            MASKING:  state_next = core_done ? SIGN : MASKING;
            KEYGEN:   state_next = core_done ? DONE : KEYGEN;
            SIGN:     state_next = core_done ? DONE : SIGN;
            default:  state_next = IDLE;
        endcase
    end

    // ------------------------------------------------------------------
    // core command and result routing
    // ------------------------------------------------------------------
    always_comb
    begin
        core_cmd.init_cmd = 1'b0;
        core_cmd.next_cmd = 1'b0;
        // iv and count feed the random-value steps
        core_cmd.entropy  = req.iv;
        core_cmd.nonce    = req.counter_nonce;
        case (state_reg)
            SEED:
                core_cmd.init_cmd = first_cycle;
            LAMBDA, SCALAR, MASKING:
                core_cmd.next_cmd = first_cycle;
            KEYGEN:
            begin
                core_cmd.init_cmd = first_cycle;
                core_cmd.entropy  = req.keygen_seed;
                core_cmd.nonce    = req.keygen_nonce;
            end
            SIGN:
            begin
                core_cmd.init_cmd = first_cycle;
                core_cmd.entropy  = req.priv_key;
                core_cmd.nonce    = req.hashed_msg;
            end
            default:
                core_cmd.next_cmd = 1'b0;
        endcase
    end

    // destination register per step
    always_comb
    begin
        step_state = 1'b1;
        case (state_reg)
            SEED:         wr_dest = SEED_D;
            LAMBDA:       wr_dest = LAMBDA_D;
            SCALAR:       wr_dest = SCALAR_D;
            MASKING:      wr_dest = MASKING_D;
            KEYGEN, SIGN: wr_dest = K_D;
            default:
            begin
                // no write outside the command steps
                wr_dest    = SEED_D;
                step_state = 1'b0;
            end
        endcase
    end

endmodule

// ==== hw/ecc_drbg_top.sv ====
`timescale 1ns/100ps

`include "ecc_drbg_defs.svh"

module ecc_drbg_top
    import ecc_drbg_cmd_pkg::*, ecc_drbg_core_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize,
    input  logic                          en,
    input  drbg_mode_e                    mode,
    input  logic [`ECC_DRBG_REG_SIZE-1:0] keygen_seed,
    input  logic [`ECC_DRBG_REG_SIZE-1:0] keygen_nonce,
    input  logic [`ECC_DRBG_REG_SIZE-1:0] priv_key,
    input  logic [`ECC_DRBG_REG_SIZE-1:0] hashed_msg,
    input  logic [`ECC_DRBG_REG_SIZE-1:0] iv,
    output logic                          ready,
    output logic                          done,
    output logic [`ECC_DRBG_REG_SIZE-1:0] lambda,
    output logic [`ECC_DRBG_REG_SIZE-1:0] scalar_rnd,
    output logic [`ECC_DRBG_REG_SIZE-1:0] masking_rnd,
    output logic [`ECC_DRBG_REG_SIZE-1:0] drbg
);

    logic                          start;
    drbg_req_t                     req;
    drbg_core_cmd_t                core_cmd;
    logic [`ECC_DRBG_REG_SIZE-1:0] seed_in;
    logic [`ECC_DRBG_REG_SIZE-1:0] seed;
    logic                          core_valid;
    logic [`ECC_DRBG_REG_SIZE-1:0] core_result;
    logic                          wr_en;
    drbg_dest_e                    wr_dest;

    // ------------------------------------------------------------------
    // request in, steps, mixer, results out
    // ------------------------------------------------------------------
    ecc_drbg_req_capture u_capture (
        .clk          (clk),
        .reset_n      (reset_n),
        .en           (en),
        .ready        (ready),
        .mode         (mode),
        .keygen_seed  (keygen_seed),
        .keygen_nonce (keygen_nonce),
        .priv_key     (priv_key),
        .hashed_msg   (hashed_msg),
        .iv           (iv),
        .start        (start),
        .req          (req)
    );

    ecc_drbg_sequencer u_seq (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .start      (start),
        .req        (req),
        .seed       (seed),
        .core_valid (core_valid),
        .core_cmd   (core_cmd),
        .seed_in    (seed_in),
        .wr_en      (wr_en),
        .wr_dest    (wr_dest),
        .ready      (ready),
        .done       (done)
    );

    ecc_drbg_mix_core u_core (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .cmd     (core_cmd),
        .seed_in (seed_in),
        .valid   (core_valid),
        .result  (core_result)
    );

    ecc_drbg_result_bank u_bank (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .wr_en       (wr_en),
        .wr_dest     (wr_dest),
        .wr_data     (core_result),
        .seed        (seed),
        .lambda      (lambda),
        .scalar_rnd  (scalar_rnd),
        .masking_rnd (masking_rnd),
        .drbg        (drbg)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the ecc drbg testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f tb.f --top-module ecc_drbg_tb -o sim_ecc_drbg
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion errors so the testbench gives the verdict
output=$(./obj_dir/sim_ecc_drbg +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

// ==== tb.f ====
+incdir+hw
hw/ecc_drbg_cmd_pkg.sv
hw/ecc_drbg_core_pkg.sv
hw/ecc_drbg_req_capture.sv
hw/ecc_drbg_sequencer.sv
hw/ecc_drbg_mix_core.sv
hw/ecc_drbg_result_bank.sv
hw/ecc_drbg_top.sv
verification/ecc_drbg_checker.sv
verification/ecc_drbg_tb.sv

// ==== verification/ecc_drbg_checker.sv ====
`timescale 1ns/100ps

module ecc_drbg_checker
(
    input logic clk,
    input logic reset_n,
    input logic zeroize,
    input logic en,
    input logic start,
    input logic ready,
    input logic done
);

    // count of failed assertions
    int fail_count = 0;

    // ------------------------------------------------------------------
    // top-level protocol
    // ------------------------------------------------------------------

    // done is a one-cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (!reset_n) done |=> !done)
    else
    begin
        fail_count++;
        $error("done stayed high for more than one cycle");
    end

    // requests while busy are dropped and never picked up later
    busy_ignore: assert property (@(posedge clk) disable iff (!reset_n)
                                  (ready && !en) |=> ready)
    else
    begin
        fail_count++;
        $error("an operation started without en while ready");
    end

    // ready drops once accepted
    start_busy: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
                                 start |=> !ready)
    else
    begin
        fail_count++;
        $error("ready still high after start");
    end

    // and stays low until done unless zeroized
    hold_busy: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
                                (!ready && !done) |=> !ready)
    else
    begin
        fail_count++;
        $error("ready returned before done");
    end

endmodule

bind ecc_drbg_top ecc_drbg_checker u_check (
    .clk     (clk),
    .reset_n (reset_n),
    .zeroize (zeroize),
    .en      (en),
    .start   (start),
    .ready   (ready),
    .done    (done)
);

// ==== verification/ecc_drbg_tb.sv ====
`timescale 1ns/100ps

`include "ecc_drbg_defs.svh"

module ecc_drbg_tb
    import ecc_drbg_cmd_pkg::*;
();

    localparam int W       = `ECC_DRBG_REG_SIZE;
    localparam int NUM_OPS = 11;
    // every operation budgeted as a five-step sign, then doubled
    localparam int TIMEOUT_NS = NUM_OPS * 5 * (`ECC_DRBG_ROUNDS + 3) * 20 * 2;

    typedef logic [W-1:0] word_t;

    // bank contents expected after one operation
    typedef struct packed {
        word_t lambda;
        word_t scalar_rnd;
        word_t masking_rnd;
        word_t drbg;
    } bank_t;

    logic       clk;
    logic       reset_n;
    logic       zeroize;
    logic       en;
    drbg_mode_e mode;
    word_t      keygen_seed;
    word_t      keygen_nonce;
    word_t      priv_key;
    word_t      hashed_msg;
    word_t      iv;
    logic       ready;
    logic       done;
    word_t      lambda;
    word_t      scalar_rnd;
    word_t      masking_rnd;
    word_t      drbg;

    // model state, chained across operations like the DUT
    logic [31:0] lfsr;
    word_t       model_seed;
    logic [15:0] model_count;
    bank_t       model_bank;
    bank_t       exp_q[$];
    int          errors      = 0;
    int          ops_issued  = 0;
    int          ops_checked = 0;
    int          tests_run   = 0;

    ecc_drbg_top u_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("ERROR: watchdog expired, %0d of %0d operations checked",
                 ops_checked, ops_issued);
        $display("Test FAILED");
        $finish;
    end

    // ------------------------------------------------------------------
    // random source and reference model
    // ------------------------------------------------------------------

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic word_t random_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[W-2:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic drbg_mode_e random_mode();
        logic [1:0] v;
        v = 2'(random_bits(2));
        // code 3 is unused, fold it onto sign
        if (v == 2'b11)
            v = 2'b01;
        return drbg_mode_e'(v);
    endfunction

    // one init or next command, key and state carry on to the next call
    function automatic word_t mix_ref(inout word_t key, inout word_t state);
        for (int r = 0; r < `ECC_DRBG_ROUNDS; r++)
        begin
            state = ((state << 13) | (state >> (W - 13))) ^ key;
            state = state + word_t'(r);
            key   = (key >> 7) | (key << (W - 7));
        end
        // at most one subtraction of the group order
        if (state >= `ECC_DRBG_GROUP_ORDER)
            return state - `ECC_DRBG_GROUP_ORDER;
        return state;
    endfunction

    task automatic model_op(
        input drbg_mode_e m,
        input word_t      ks,
        input word_t      kn,
        input word_t      pk,
        input word_t      hm,
        input word_t      iv_v
    );
        word_t cn;
        word_t key;
        word_t state;
        model_count = model_count + 16'd1;
        cn          = {4{model_count}};
        // seed refresh
        key        = iv_v ^ cn;
        state      = model_seed ^ cn;
        model_seed = mix_ref(key, state);
        // lambda and scalar by next, step count folded in
        state                 = state ^ 64'd1;
        model_bank.lambda     = mix_ref(key, state);
        state                 = state ^ 64'd2;
        model_bank.scalar_rnd = mix_ref(key, state);
        if (m == MODE_SIGN)
        begin
            state                  = state ^ 64'd3;
            model_bank.masking_rnd = mix_ref(key, state);
            key                    = pk ^ hm;
            state                  = model_seed ^ cn;
            model_bank.drbg        = mix_ref(key, state);
        end
        else if (m == MODE_KEYGEN)
        begin
            key             = ks ^ kn;
            state           = model_seed ^ cn;
            model_bank.drbg = mix_ref(key, state);
        end
    endtask

    // ------------------------------------------------------------------
    // compare tasks and compare process
    // ------------------------------------------------------------------
    task automatic check_word(input string name, input word_t got, input word_t want);
        if (got !== want)
        begin
            $display("MISMATCH %s: got 0x%016h expected 0x%016h", name, got, want);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want)
        begin
            $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, want);
            errors++;
        end
    endtask

    task automatic check_bank(input bank_t want);
        check_word("lambda", lambda, want.lambda);
        check_word("scalar_rnd", scalar_rnd, want.scalar_rnd);
        check_word("masking_rnd", masking_rnd, want.masking_rnd);
        check_word("drbg", drbg, want.drbg);
    endtask

    // outputs sampled mid-cycle, away from the rising edge
    initial
    begin
        bank_t want;
        forever
        begin
            @(negedge clk);
            if (done)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("ERROR: done pulse with no operation outstanding");
                    errors++;
                end
                else
                begin
                    want = exp_q.pop_front();
                    check_bank(want);
                end
                check_flag("ready", ready, 1'b0);
                @(negedge clk);
                // done lasts one cycle, ready right after
                check_flag("done", done, 1'b0);
                check_flag("ready", ready, 1'b1);
                ops_checked++;
            end
        end
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------

    // called on a falling edge
    task automatic issue_op(input drbg_mode_e m);
        while (!ready)
            @(negedge clk);
        keygen_seed  = random_bits(W);
        keygen_nonce = random_bits(W);
        priv_key     = random_bits(W);
        hashed_msg   = random_bits(W);
        iv           = random_bits(W);
        mode         = m;
        en           = 1'b1;
        model_op(m, keygen_seed, keygen_nonce, priv_key, hashed_msg, iv);
        exp_q.push_back(model_bank);
        ops_issued++;
        @(negedge clk);
        en = 1'b0;
    endtask

    // new operands and stray en pulses while the DUT is busy
    task automatic disturb_busy();
        repeat (3)
        begin
            keygen_seed = random_bits(W);
            priv_key    = random_bits(W);
            iv          = random_bits(W);
            mode        = random_mode();
            en          = 1'b1;
            @(negedge clk);
            en = 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic wait_checked();
        while (ops_checked != ops_issued)
            @(negedge clk);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before)
            $display("test %0d %s: pass", tests_run, name);
        else
            $display("test %0d %s: fail, %0d errors", tests_run, name,
                     errors - errors_before);
    endtask

    initial
    begin
        int base;
        lfsr         = 32'h0703_999f;
        model_seed   = `ECC_DRBG_SEED_INIT;
        model_count  = '0;
        model_bank   = '0;
        reset_n      = 1'b0;
        zeroize      = 1'b0;
        en           = 1'b0;
        mode         = MODE_KEYGEN;
        keygen_seed  = '0;
        keygen_nonce = '0;
        priv_key     = '0;
        hashed_msg   = '0;
        iv           = '0;
        repeat (5) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        base = errors;
        issue_op(MODE_KEYGEN);
        wait_checked();
        report_test("keygen", base);

        base = errors;
        issue_op(MODE_SIGN);
        wait_checked();
        report_test("sign", base);

        base = errors;
        issue_op(MODE_DH_SHARED);
        wait_checked();
        report_test("shared secret", base);

        // back to back, seed and count chain through the model
        base = errors;
        repeat (6)
        begin
            issue_op(random_mode());
            disturb_busy();
        end
        wait_checked();
        report_test("random back to back", base);

        // abort a sign inside its lambda step
        base = errors;
        issue_op(MODE_SIGN);
        repeat (15) @(negedge clk);
        zeroize = 1'b1;
        @(negedge clk);
        zeroize = 1'b0;
        // aborted operation never reports done
        exp_q.delete();
        ops_issued = ops_checked;
        model_seed = `ECC_DRBG_SEED_INIT;
        model_bank = '0;
        check_bank(model_bank);
        check_flag("ready", ready, 1'b1);
        issue_op(MODE_KEYGEN);
        wait_checked();
        report_test("zeroize", base);

        $display("%0d tests, %0d operations checked, %0d errors, %0d assertion failures",
                 tests_run, ops_checked, errors, u_dut.u_check.fail_count);
        if (errors == 0 && u_dut.u_check.fail_count == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule
